// ==== verilog.f ====
+incdir+logic
+incdir+verification
logic/aesDecPkg.sv
logic/invSbox.sv
logic/invMixColumns.sv
logic/invRoundDatapath.sv
logic/roundKeyStore.sv
logic/aesDecryptCtrl.sv
logic/aesDecryptTop.sv
verification/aesDecryptTbClock.sv
verification/aesDecryptTb.sv

// ==== verification/aesTbModel.svh ====
// xorshift32 state, advanced once per call of nextRandom.
logic [31:0] rngState = 32'd61992;

// forward S-box, filled once by buildSbox before the first test.
byteT sboxTable [0:255];

function automatic logic [31:0] nextRandom();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
endfunction

function automatic blockT randomBlock();
    blockT blk;
    blk = '0;
    for (int i = 0; i < 4; i++)
        blk = {blk[95:0], nextRandom()};
    return blk;
endfunction

function automatic byteT gfMultiply(input byteT a, input byteT b);
    byteT prod;
    byteT x;
    byteT y;
    prod = '0;
    x = a;
    y = b;
    while (y != 8'h00)
    begin
        if (y[0])
            prod = prod ^ x;
        x = (x << 1) ^ (x[7] ? `AES_GF_REDUCE : 8'h00);
        y = y >> 1;
    end
    return prod;
endfunction

// the inverse is found by search, then the forward affine map is applied.
task automatic buildSbox();
    byteT inv;
    for (int v = 0; v < 256; v++)
    begin
        inv = 8'h00;
        for (int y = 1; y < 256; y++)
        begin
            if (gfMultiply(byteT'(v), byteT'(y)) == 8'h01)
                inv = byteT'(y);
        end
        sboxTable[v] = inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
                     ^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
    end
endtask

function automatic expKeyT expandKey(input blockT key);
    wordT   w [0:`AES_KEYWORDS-1];
    wordT   temp;
    byteT   rcon;
    expKeyT sched;
    rcon = 8'h01;
    sched = '0;
    for (int i = 0; i < `AES_KEYWORDS; i++)
    begin
        if (i < 4)
            w[i] = key[127-32*i -: 32];
        else
        begin
            temp = w[i-1];
            if (i % 4 == 0)
            begin
                temp = {temp[23:0], temp[31:24]};
                temp = {sboxTable[temp[31:24]], sboxTable[temp[23:16]],
                        sboxTable[temp[15:8]], sboxTable[temp[7:0]]};
                temp[31:24] = temp[31:24] ^ rcon;
                rcon = gfMultiply(rcon, 8'h02);
            end
            w[i] = w[i-4] ^ temp;
        end
        sched[32*i +: 32] = w[i];
    end
    return sched;
endfunction

function automatic blockT roundKeyOf(input expKeyT sched, input int r);
    return {sched[32*(4*r) +: 32], sched[32*(4*r+1) +: 32],
            sched[32*(4*r+2) +: 32], sched[32*(4*r+3) +: 32]};
endfunction

// row r of the forward matrix is 02 at column r, 03 next, then 01 and 01.
function automatic blockT mixColumnsFwd(input blockT st);
    blockT res;
    byteT  a [0:3];
    for (int c = 0; c < 4; c++)
    begin
        for (int row = 0; row < 4; row++)
            a[row] = st[127-32*c-8*row -: 8];
        for (int row = 0; row < 4; row++)
            res[127-32*c-8*row -: 8] = gfMultiply(a[row], 8'h02)
                                     ^ gfMultiply(a[(row+1)%4], 8'h03)
                                     ^ a[(row+2)%4] ^ a[(row+3)%4];
    end
    return res;
endfunction

function automatic blockT encryptBlock(input blockT pt, input expKeyT sched);
    blockT st;
    blockT nx;
    st = pt ^ roundKeyOf(sched, 0);
    for (int r = 1; r <= `AES_NR; r++)
    begin
        // shift rows moves row r left, so byte (row, c) comes from column c + row.
        for (int c = 0; c < 4; c++)
        begin
            for (int row = 0; row < 4; row++)
                nx[127-32*c-8*row -: 8] = sboxTable[st[127-32*((c+row)%4)-8*row -: 8]];
        end
        if (r != `AES_NR)
            nx = mixColumnsFwd(nx);
        st = nx ^ roundKeyOf(sched, r);
    end
    return st;
endfunction

// ==== verification/aesDecryptTb.sv ====
`timescale 1ns/1ps
`include "aesDec_params.svh"

module aesDecryptTb
    import aesDecPkg::*;
();

    localparam int numRandom = 200;
    // the known-answer block, the random blocks and the run with a second strobe.
    localparam int numTests = numRandom + 2;
    localparam int clkPeriodNs = 40;
    localparam int watchdogCycles = (numTests + 4) * 16;

    logic   clk;
    logic   rstN;
    logic   inValid;
    blockT  cipherText;
    expKeyT expandedKey;
    logic   outValid;
    blockT  plainText;

    int pulseCount = 0;
    int runsDone = 0;

    `include "aesTbModel.svh"

    aesDecryptTbClock clockGen_i
    (
        .clk  (clk),
        .rstN (rstN)
    );

    aesDecryptTop aesDecryptTop_i
    (
        .clk         (clk),
        .rstN        (rstN),
        .inValid     (inValid),
        .cipherText  (cipherText),
        .expandedKey (expandedKey),
        .outValid    (outValid),
        .plainText   (plainText)
    );

    // counts every cycle in which outValid is high.
    always @(negedge clk)
    begin
        if (rstN && outValid === 1'b1)
            pulseCount++;
    end

    task automatic failRun();
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkBlock(input string what, input blockT got, input blockT expected);
        if (got !== expected)
        begin
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, expected);
            failRun();
        end
    endtask

    task automatic checkStrobe(input string what, input int got, input int expected);
        if (got != expected)
        begin
            $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, expected);
            failRun();
        end
    endtask

    // sends one block and waits for outValid. With intrude set, a second strobe
    // with other data is sent while the first block is still in the rounds.
    task automatic runBlock(input blockT ct, input expKeyT sched, input bit intrude,
                            output blockT result, output int latency);
        bit done;
        done = 1'b0;
        latency = 0;
        @(posedge clk);
        inValid     <= 1'b1;
        cipherText  <= ct;
        expandedKey <= sched;
        @(posedge clk);
        // the core latched its inputs on this edge, so they may change now.
        inValid     <= 1'b0;
        cipherText  <= ~ct;
        expandedKey <= ~sched;
        checkStrobe("outValid cycles before this run", pulseCount, runsDone);
        while (!done)
        begin
            @(posedge clk);
            latency++;
            if (intrude && latency == 4)
            begin
                inValid     <= 1'b1;
                cipherText  <= randomBlock();
                expandedKey <= expandKey(randomBlock());
            end
            else
                inValid <= 1'b0;
            @(negedge clk);
            if (outValid === 1'b1)
                done = 1'b1;
            else if (latency >= 40)
            begin
                $display("outValid did not rise within %0d cycles of the accepting edge", latency);
                failRun();
            end
        end
        result = plainText;
        runsDone++;
    endtask

    initial
    begin
        #(watchdogCycles * clkPeriodNs);
        $display("the run timed out after %0d clock cycles without finishing", watchdogCycles);
        failRun();
    end

    initial
    begin
        blockT  key;
        blockT  pt;
        blockT  ct;
        blockT  result;
        expKeyT sched;
        int     latency;

        inValid = 1'b0;
        cipherText = '0;
        expandedKey = '0;
        buildSbox();
        wait (rstN === 1'b1);

        // with no strobe the core must stay quiet.
        repeat (10) @(negedge clk);
        checkStrobe("outValid cycles after reset", pulseCount, 0);
        checkBlock("plainText after reset", plainText, '0);

        key = 128'h000102030405060708090a0b0c0d0e0f;
        pt = 128'h00112233445566778899aabbccddeeff;
        ct = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
        sched = expandKey(key);
        checkBlock("model ciphertext of the FIPS-197 example", encryptBlock(pt, sched), ct);
        runBlock(ct, sched, 1'b0, result, latency);
        checkStrobe("outValid latency", latency, 11);
        checkBlock("FIPS-197 plaintext", result, pt);
        repeat (3)
        begin
            @(negedge clk);
            checkBlock("plainText held while idle", plainText, pt);
        end

        // each block is sent in the cycle right after the previous outValid.
        for (int i = 0; i < numRandom; i++)
        begin
            key = randomBlock();
            pt = randomBlock();
            sched = expandKey(key);
            ct = encryptBlock(pt, sched);
            runBlock(ct, sched, 1'b0, result, latency);
            checkStrobe("outValid latency", latency, 11);
            checkBlock("random plaintext", result, pt);
        end

        key = randomBlock();
        pt = randomBlock();
        sched = expandKey(key);
        ct = encryptBlock(pt, sched);
        runBlock(ct, sched, 1'b1, result, latency);
        checkStrobe("outValid latency with a second strobe", latency, 11);
        checkBlock("plaintext with a second strobe", result, pt);
        repeat (15) @(negedge clk);
        checkStrobe("outValid cycles after the ignored strobe", pulseCount, runsDone);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== verification/aesDecryptTbClock.sv ====
`timescale 1ns/1ps

module aesDecryptTbClock
(
    output logic clk,
    output logic rstN
);

    initial
    begin
        clk = 1'b0;
        forever
            #20 clk = ~clk;
    end

    // reset stays low over the first two rising edges.
    initial
    begin
        rstN = 1'b0;
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
    end

endmodule

// ==== logic/aesDecryptTop.sv ====
`timescale 1ns/1ps

module aesDecryptTop
    import aesDecPkg::*;
(
    input  logic   clk,
    input  logic   rstN,
    input  logic   inValid,
    input  blockT  cipherText,
    input  expKeyT expandedKey,
    output logic   outValid,
    output blockT  plainText
);

    logic     keyLoad;
    roundIdxT keyRound;
    blockT    roundKey;
    blockT    roundState;
    logic     finalRound;
    blockT    nextState;

    aesDecryptCtrl aesDecryptCtrl_i
    (
        .clk        (clk),
        .rstN       (rstN),
        .inValid    (inValid),
        .cipherText (cipherText),
        .roundKey   (roundKey),
        .nextState  (nextState),
        .keyLoad    (keyLoad),
        .keyRound   (keyRound),
        .roundState (roundState),
        .finalRound (finalRound),
        .outValid   (outValid),
        .plainText  (plainText)
    );

    roundKeyStore roundKeyStore_i
    (
        .clk         (clk),
        .rstN        (rstN),
        .keyLoad     (keyLoad),
        .expandedKey (expandedKey),
        .keyRound    (keyRound),
        .roundKey    (roundKey)
    );

    invRoundDatapath invRoundDatapath_i
    (
        .roundState (roundState),
        .roundKey   (roundKey),
        .finalRound (finalRound),
        .nextState  (nextState)
    );

endmodule

// ==== logic/aesDecryptCtrl.sv ====
`timescale 1ns/1ps
`include "aesDec_params.svh"

module aesDecryptCtrl
    import aesDecPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  logic     inValid,
    input  blockT    cipherText,
    input  blockT    roundKey,
    input  blockT    nextState,
    output logic     keyLoad,
    output roundIdxT keyRound,
    output blockT    roundState,
    output logic     finalRound,
    output logic     outValid,
    output blockT    plainText
);

    decStateT curState;

    // a strobe is only taken while idle, so one block is in flight at a time.
    assign keyLoad    = (curState == IDLE) && inValid;
    assign finalRound = (keyRound == '0);

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            curState  <= IDLE;
            keyRound  <= '0;
            outValid  <= 1'b0;
            plainText <= '0;
        end
        else
        begin
            outValid <= 1'b0;
            case (curState)
                IDLE:
                begin
                    if (inValid)
                    begin
                        keyRound <= roundIdxT'(`AES_NR);
                        curState <= WHITEN;
                    end
                end
                WHITEN:
                begin
                    keyRound <= keyRound - 4'd1;
                    curState <= ROUNDS;
                end
                ROUNDS:
                begin
                    if (finalRound)
                    begin
                        outValid  <= 1'b1;
                        plainText <= nextState;
                        curState  <= IDLE;
                    end
                    else
                        keyRound <= keyRound - 4'd1;
                end
                default:
                    curState <= IDLE;
            endcase
        end
    end

    // whitening uses round key 10, then each edge in ROUNDS takes one inverse round.
    always_ff @(posedge clk)
    begin
        if (keyLoad)
            roundState <= cipherText;
        else if (curState == WHITEN)
            roundState <= roundState ^ roundKey;
        else if (curState == ROUNDS)
            roundState <= nextState;
    end

    singleStrobe: assert property (@(posedge clk) disable iff (!rstN)
        outValid |=> !outValid);

    roundBound: assert property (@(posedge clk) disable iff (!rstN)
        keyRound <= roundIdxT'(`AES_NR));

endmodule

// ==== logic/roundKeyStore.sv ====
`timescale 1ns/1ps
`include "aesDec_params.svh"

module roundKeyStore
    import aesDecPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  logic     keyLoad,
    input  expKeyT   expandedKey,
    input  roundIdxT keyRound,
    output blockT    roundKey
);

    wordT       keyWords [0:`AES_KEYWORDS-1];
    logic [5:0] baseIdx;
    logic       loaded;

    always_ff @(posedge clk)
    begin
        if (keyLoad)
        begin
            for (int i = 0; i < `AES_KEYWORDS; i++)
                keyWords[i] <= expandedKey[32*i +: 32];
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
            loaded <= 1'b0;
        else if (keyLoad)
            loaded <= 1'b1;
    end

    // word 4r lands in column 0, the top of the block.
    assign baseIdx  = 6'(keyRound) * 6'(`AES_NB);
    assign roundKey = {keyWords[baseIdx], keyWords[baseIdx + 6'd1],
                       keyWords[baseIdx + 6'd2], keyWords[baseIdx + 6'd3]};

    keyRoundInRange: assert property (@(posedge clk) disable iff (!rstN)
        loaded |-> keyRound <= roundIdxT'(`AES_NR));

endmodule

// ==== logic/invRoundDatapath.sv ====
`timescale 1ns/1ps

module invRoundDatapath
    import aesDecPkg::*;
(
    input  blockT roundState,
    input  blockT roundKey,
    input  logic  finalRound,
    output blockT nextState
);

    blockT shifted;
    blockT substituted;
    blockT keyed;
    blockT mixed;

    // inverse shift rows moves row r right by r columns, so byte (r, c)
    // comes from column c - r.
    for (genvar c = 0; c < 4; c++)
    begin : genShiftCol
        for (genvar r = 0; r < 4; r++)
        begin : genShiftRow
            assign shifted[127-32*c-8*r -: 8] =
                roundState[127-32*((c+4-r)%4)-8*r -: 8];
        end
    end

    for (genvar b = 0; b < 16; b++)
    begin : genSbox
        invSbox invSbox_i
        (
            .inByte  (shifted[127-8*b -: 8]),
            .outByte (substituted[127-8*b -: 8])
        );
    end

    assign keyed = substituted ^ roundKey;

    invMixColumns invMixColumns_i
    (
        .inBlock  (keyed),
        .outBlock (mixed)
    );

    // the last round leaves out the column mixing.
    assign nextState = finalRound ? keyed : mixed;

endmodule

// ==== logic/invMixColumns.sv ====
`timescale 1ns/1ps
`include "aesDec_params.svh"

module invMixColumns
    import aesDecPkg::*;
(
    input  blockT inBlock,
    output blockT outBlock
);

    function automatic byteT xtime(input byteT a);
        return {a[6:0], 1'b0} ^ (a[7] ? `AES_GF_REDUCE : 8'h00);
    endfunction

    // the four matrix constants are sums of a, 2a, 4a and 8a.
    function automatic byteT mul09(input byteT a);
        return xtime(xtime(xtime(a))) ^ a;
    endfunction

    function automatic byteT mul0b(input byteT a);
        return xtime(xtime(xtime(a))) ^ xtime(a) ^ a;
    endfunction

    function automatic byteT mul0d(input byteT a);
        return xtime(xtime(xtime(a))) ^ xtime(xtime(a)) ^ a;
    endfunction

    function automatic byteT mul0e(input byteT a);
        return xtime(xtime(xtime(a))) ^ xtime(xtime(a)) ^ xtime(a);
    endfunction

    for (genvar c = 0; c < 4; c++)
    begin : genCol
        wordT colIn;
        byteT a0;
        byteT a1;
        byteT a2;
        byteT a3;

        assign colIn = inBlock[127-32*c -: 32];
        assign a0 = colIn[31:24];
        assign a1 = colIn[23:16];
        assign a2 = colIn[15:8];
        assign a3 = colIn[7:0];

        // circulant rows 0e 0b 0d 09.
        assign outBlock[127-32*c -: 8] = mul0e(a0) ^ mul0b(a1) ^ mul0d(a2) ^ mul09(a3);
        assign outBlock[119-32*c -: 8] = mul09(a0) ^ mul0e(a1) ^ mul0b(a2) ^ mul0d(a3);
        assign outBlock[111-32*c -: 8] = mul0d(a0) ^ mul09(a1) ^ mul0e(a2) ^ mul0b(a3);
        assign outBlock[103-32*c -: 8] = mul0b(a0) ^ mul0d(a1) ^ mul09(a2) ^ mul0e(a3);
    end

endmodule

// ==== logic/invSbox.sv ====
`timescale 1ns/1ps
`include "aesDec_params.svh"

module invSbox
    import aesDecPkg::*;
(
    input  byteT inByte,
    output byteT outByte
);

    byteT affOut;
    byteT p2;
    byteT p3;
    byteT p6;
    byteT p12;
    byteT p15;
    byteT p30;
    byteT p60;
    byteT p120;
    byteT p240;
    byteT p252;

    function automatic byteT gfMul(input byteT a, input byteT b);
        byteT acc;
        byteT sh;
        acc = '0;
        sh = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                acc = acc ^ sh;
            sh = {sh[6:0], 1'b0} ^ (sh[7] ? `AES_GF_REDUCE : 8'h00);
        end
        return acc;
    endfunction

    // inverse affine map, rotations by 1, 3 and 6 plus the constant 05.
    assign affOut = {inByte[6:0], inByte[7]} ^ {inByte[4:0], inByte[7:5]}
                  ^ {inByte[1:0], inByte[7:2]} ^ 8'h05;

    // the inverse is x^254, and zero comes out as zero on its own.
    assign p2   = gfMul(affOut, affOut);
    assign p3   = gfMul(p2, affOut);
    assign p6   = gfMul(p3, p3);
    assign p12  = gfMul(p6, p6);
    assign p15  = gfMul(p12, p3);
    assign p30  = gfMul(p15, p15);
    assign p60  = gfMul(p30, p30);
    assign p120 = gfMul(p60, p60);
    assign p240 = gfMul(p120, p120);
    assign p252 = gfMul(p240, p12);

    assign outByte = gfMul(p252, p2);

endmodule

// ==== logic/aesDecPkg.sv ====
`include "aesDec_params.svh"

package aesDecPkg;

    // one state byte.
    typedef logic [7:0] byteT;

    // one column of the state or one word of the key schedule.
    typedef logic [31:0] wordT;

    // column c sits in bits 127-32c down to 96-32c, row 0 in the top byte.
    typedef logic [`AES_BLOCK_W-1:0] blockT;

    // word i of the schedule sits in bits 32i+31 down to 32i.
    typedef logic [`AES_EXPKEY_W-1:0] expKeyT;

    typedef logic [3:0] roundIdxT;

    typedef enum logic [1:0]
    {
        IDLE,
        WHITEN,
        ROUNDS
    } decStateT;

endpackage

// ==== logic/aesDec_params.svh ====
`ifndef AES_DEC_PARAMS_SVH
`define AES_DEC_PARAMS_SVH

// words of 32 bits in one block.
`define AES_NB 4

// AES-128 runs ten rounds after the initial key addition.
`define AES_NR 10

`define AES_BLOCK_W 128

// the schedule holds one four-word round key per round plus the whitening key.
`define AES_KEYWORDS 44
`define AES_EXPKEY_W 1408

// low byte of x^8 + x^4 + x^3 + x + 1.
`define AES_GF_REDUCE 8'h1b

`endif
